// File: gb_host_top.f
+incdir+.
gb_host_pkg.sv
download_decoder.sv
cheat_code_loader.sv
palette_loader.sv
fast_forward_latch.sv
backup_ram_sequencer.sv
gb_host_top.sv
tb_gb_host_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the host glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_gb_host_top -f gb_host_top.f -o tb_gb_host_top

./obj_dir/tb_gb_host_top | tee sim.log

if grep -q "All tests passed" sim.log; then
	echo "Simulation PASS"
else
	echo "Simulation FAIL"
	exit 1
fi

// File: tb_gb_host_ref.svh
/* Reference model of the host glue and typed compare tasks,
   included inside the testbench module */
`ifndef TB_GB_HOST_REF_SVH
`define TB_GB_HOST_REF_SVH

	////////////////////
	// Reference model
	////////////////////

	// File type to download kind, megaduck checked before the cart codes
	function automatic download_kind_e ref_kind(input logic dl, input filetype_t ft);
		if (!dl)
			return KIND_NONE;
		if (ft == 8'h81)
			return KIND_MEGADUCK;
		if (ft[5:0] == 6'h01 || ft == 8'h80)
			return KIND_CART;
		case (ft)
			8'h02:   return KIND_SGB_BORDER;
			8'h03:   return KIND_PALETTE;
			8'h04:   return KIND_CGB_BOOT;
			8'h05:   return KIND_DMG_BOOT;
			8'h06:   return KIND_SGB_BOOT;
			8'hFF:   return KIND_CHEAT;
			default: return KIND_NONE;
		endcase
	endfunction

	// Eight words, bottom half of each field first
	function automatic gg_code_t ref_gg(input ioctl_data_t w [8]);
		gg_code_t r;
		r.strobe  = 1'b0;
		r.flags   = {w[1], w[0]};
		r.address = {w[3], w[2]};
		r.compare = {w[5], w[4]};
		r.replace = {w[7], w[6]};
		return r;
	endfunction

	function automatic palette_t ref_pal_shift(input palette_t p, input ioctl_data_t w);
		return (p << 16) | palette_t'({w[7:0], w[15:8]});
	endfunction

	// Save RAM blocks, plus one when the clock block is in use
	function automatic int ref_blocks(input block_mask_t mask, input logic rtc);
		return int'(mask) + 1 + (rtc ? 1 : 0);
	endfunction

	function automatic ioctl_data_t ref_save_word(input int blk, input int idx,
		input block_mask_t mask, input ioctl_data_t q, input rtc_stamp_t ts,
		input rtc_saved_t st);
		if (blk <= int'(mask))
			return q;
		case (idx)
			0:       return ts[15:0];
			1:       return ts[31:16];
			2:       return st[15:0];
			3:       return st[31:16];
			4:       return st[47:32];
			default: return 16'hFFFF;
		endcase
	endfunction

	// Fast-forward state after a release
	function automatic logic ref_tap_latches(input int hold, input logic prev_latched,
		input int limit);
		return (hold < limit) && !prev_latched;
	endfunction

	// Backup RAM contents seen on bk_q
	function automatic ioctl_data_t mem_word(input logic [15:0] addr);
		return (addr * 16'h9E37) ^ {addr[7:0], addr[15:8]};
	endfunction

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_kind(input string name, input download_kind_e got,
		input download_kind_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_gg(input string name, input gg_code_t got, input gg_code_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_pal(input string name, input palette_t got, input palette_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input ioctl_data_t got,
		input ioctl_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic fail_note(input string msg);
		errors++;
		$display("%s", msg);
	endtask

`endif

// File: tb_gb_host_top.sv
/* Testbench for the host glue: clock, stimulus, storage host model,
   watchdog and the test sequence */
`timescale 1ns/1ns

module tb_gb_host_top import gb_host_pkg::*; ();

	localparam int FF_HOLD     = 20;
	localparam int TEST_CYCLES = 4000;

	logic           clk_sys;
	logic           reset;
	logic           ioctl_download;
	logic           ioctl_wr;
	ioctl_addr_t    ioctl_addr;
	ioctl_data_t    ioctl_dout;
	filetype_t      filetype;
	logic           ff_button;
	logic           osd_status;
	logic           sd_ack;
	buff_addr_t     sd_buff_addr;
	ioctl_data_t    sd_buff_dout;
	logic           sd_buff_wr;
	logic           img_mounted;
	logic           img_readonly;
	logic [63:0]    img_size;
	logic           bk_load_req;
	logic           bk_save_req;
	logic           autosave;
	logic           cram_wr;
	logic           cart_has_save;
	block_mask_t    ram_mask_file;
	logic           rtc_inuse;
	rtc_stamp_t     rtc_timestamp;
	rtc_saved_t     rtc_savedtime;
	ioctl_data_t    bk_q;
	download_kind_e download_kind;
	logic           using_real_cgb_bios;
	gg_code_t       gg_code;
	logic           gg_reset;
	palette_t       palette;
	logic           fast_forward;
	lba_t           sd_lba;
	logic           sd_rd;
	logic           sd_wr;
	ioctl_data_t    sd_buff_din;
	logic [15:0]    bk_addr;
	ioctl_data_t    bk_data;
	logic           bk_wr;
	logic           bk_rtc_wr;
	logic           bk_loading;
	logic           sav_pending;
	logic           sav_supported;

	// Bookkeeping shared with the storage host
	int   errors;
	int   checks;
	int   exp_block;
	int   blocks_done;
	logic exp_load;

	`include "tb_gb_host_ref.svh"

	gb_host_top #(.FF_HOLD_CYCLES(FF_HOLD)) dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin : watchdog
		repeat (TEST_CYCLES * 3 / 2) @(posedge clk_sys);
		$display("Watchdog expired before the test sequence finished");
		$display("Some tests failed");
		$finish;
	end

	////////////////////
	// Storage host
	////////////////////

	// Answers each block request after 2 to 6 cycles, one word per ack cycle
	initial begin : storage_host
		int          lat;
		int          blk;
		logic        load;
		ioctl_data_t word;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		bk_q         = '0;
		forever begin
			@(negedge clk_sys);
			if (!reset && (sd_rd || sd_wr)) begin
				load = sd_rd;
				blk  = int'(sd_lba);
				check_word("sd_lba", sd_lba[15:0], 16'(exp_block));
				check_bit("sd_rd", sd_rd, exp_load);
				check_bit("bk_loading", bk_loading, exp_load);
				lat = 2 + int'($urandom_range(4));
				repeat (lat) @(posedge clk_sys);
				for (int i = 0; i < 8; i++) begin
					word = ioctl_data_t'($urandom);
					sd_ack       <= 1'b1;
					sd_buff_addr <= buff_addr_t'(i);
					sd_buff_wr   <= load;
					sd_buff_dout <= word;
					bk_q         <= mem_word({8'(blk), 8'(i)});
					@(negedge clk_sys);
					if (load) begin
						check_word("bk_data", bk_data, word);
						check_word("bk_addr", bk_addr, {8'(blk), 8'(i)});
						check_bit("bk_wr", bk_wr, blk <= int'(ram_mask_file));
						check_bit("bk_rtc_wr", bk_rtc_wr, blk > int'(ram_mask_file));
					end else begin
						check_word("sd_buff_din", sd_buff_din, ref_save_word(blk, i,
							ram_mask_file, mem_word({8'(blk), 8'(i)}),
							rtc_timestamp, rtc_savedtime));
					end
					@(posedge clk_sys);
				end
				sd_ack     <= 1'b0;
				sd_buff_wr <= 1'b0;
				exp_block++;
				blocks_done++;
			end
		end
	end

	////////////////////
	// Helper tasks
	////////////////////

	task automatic write_download(input ioctl_addr_t addr, input ioctl_data_t data);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	// Waits for n blocks and an idle sequencer, then checks nothing follows
	task automatic wait_transfer(input int n);
		int cycles;
		cycles = 0;
		while ((blocks_done < n || bk_loading) && cycles < 500) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (cycles >= 500)
			fail_note("Backup RAM transfer did not finish within 500 cycles");
		// Long enough for a whole extra block to be answered
		repeat (20) @(negedge clk_sys);
		check_bit("sd_rd|sd_wr", sd_rd | sd_wr, 1'b0);
		check_word("blocks_done", 16'(blocks_done), 16'(n));
		check_bit("bk_loading", bk_loading, 1'b0);
	endtask

	// Cart download with a writable image, then the automatic load
	task automatic run_cart_load(input logic rtc);
		block_mask_t mask;
		mask        = block_mask_t'($urandom_range(3));
		exp_block   = 0;
		exp_load    = 1'b1;
		blocks_done = 0;
		@(posedge clk_sys);
		ram_mask_file  <= mask;
		rtc_inuse      <= rtc;
		filetype       <= 8'h01;
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_sys);
		// Saves are off until the image is mounted again
		@(negedge clk_sys);
		check_bit("sav_supported", sav_supported, 1'b0);
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		@(negedge clk_sys);
		check_bit("sav_supported", sav_supported, 1'b1);
		repeat (3) @(posedge clk_sys);
		ioctl_download <= 1'b0;
		wait_transfer(ref_blocks(mask, rtc));
	endtask

	task automatic tap(input int n, input logic menu, inout logic prev_latched);
		logic exp;
		exp = menu ? prev_latched : ref_tap_latches(n, prev_latched, FF_HOLD);
		@(posedge clk_sys);
		osd_status <= menu;
		ff_button  <= 1'b1;
		repeat (n) @(posedge clk_sys);
		ff_button <= 1'b0;
		repeat (3) @(negedge clk_sys);
		check_bit("fast_forward", fast_forward, exp);
		prev_latched = exp;
		@(posedge clk_sys);
		osd_status <= 1'b0;
	endtask

	task automatic report_test(input string name, input int start);
		if (errors == start)
			$display("%-10s done, no errors", name);
		else
			$display("%-10s done, %0d errors", name, errors - start);
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin : test_sequence
		int          start;
		int          n;
		filetype_t   ft;
		filetype_t   codes [12];
		ioctl_data_t words [8];
		ioctl_data_t w;
		palette_t    pal_exp;
		logic        latched;
		void'($urandom(87));
		errors         = 0;
		checks         = 0;
		exp_block      = 0;
		blocks_done    = 0;
		exp_load       = 1'b0;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		filetype       = '0;
		ff_button      = 1'b0;
		osd_status     = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = 64'h0002_0000;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		autosave       = 1'b0;
		cram_wr        = 1'b0;
		cart_has_save  = 1'b1;
		ram_mask_file  = '0;
		rtc_inuse      = 1'b0;
		rtc_timestamp  = rtc_stamp_t'($urandom);
		rtc_savedtime  = {16'($urandom), 32'($urandom)};
		codes = '{8'h01, 8'h41, 8'h81, 8'h80, 8'h02, 8'h03,
			8'h04, 8'h05, 8'h06, 8'hFF, 8'h00, 8'h07};
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;

		// Outputs come out of reset low
		start = errors;
		@(negedge clk_sys);
		check_bit("sd_rd", sd_rd, 1'b0);
		check_bit("sd_wr", sd_wr, 1'b0);
		check_bit("bk_wr", bk_wr, 1'b0);
		check_bit("bk_rtc_wr", bk_rtc_wr, 1'b0);
		check_bit("bk_loading", bk_loading, 1'b0);
		check_bit("sav_pending", sav_pending, 1'b0);
		check_bit("sav_supported", sav_supported, 1'b0);
		check_bit("fast_forward", fast_forward, 1'b0);
		check_bit("gg_code.strobe", gg_code.strobe, 1'b0);
		check_bit("using_real_cgb_bios", using_real_cgb_bios, 1'b0);
		report_test("reset", start);

		// Every listed code, then random file types
		start = errors;
		for (int i = 0; i < 32; i++) begin
			ft = (i < 12) ? codes[i] : filetype_t'($urandom);
			for (int d = 0; d < 2; d++) begin
				@(posedge clk_sys);
				filetype       <= ft;
				ioctl_download <= d[0];
				@(negedge clk_sys);
				check_kind($sformatf("download_kind ft=%h dl=%0d", ft, d),
					download_kind, ref_kind(d[0], ft));
			end
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(negedge clk_sys);
		check_bit("using_real_cgb_bios", using_real_cgb_bios, 1'b1);
		report_test("decode", start);

		start = errors;
		@(posedge clk_sys);
		filetype       <= 8'hFF;
		ioctl_download <= 1'b1;
		for (int k = 0; k < 8; k++) begin
			words[k] = ioctl_data_t'($urandom);
			@(posedge clk_sys);
			ioctl_wr   <= 1'b1;
			ioctl_addr <= ioctl_addr_t'(2 * k);
			ioctl_dout <= words[k];
			@(negedge clk_sys);
			check_bit("gg_reset", gg_reset, k == 0);
			check_bit("gg_code.strobe", gg_code.strobe, 1'b0);
		end
		// Strobe only on the cycle after the last word
		for (int j = 0; j < 4; j++) begin
			@(posedge clk_sys);
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			@(negedge clk_sys);
			check_bit("gg_code.strobe", gg_code.strobe, j == 0);
		end
		check_gg("gg_code", gg_code, ref_gg(words));
		report_test("cheat", start);

		start = errors;
		check_pal("palette", palette, PALETTE_RESET);
		pal_exp = PALETTE_RESET;
		n = 4 + int'($urandom_range(8));
		@(posedge clk_sys);
		filetype       <= 8'h03;
		ioctl_download <= 1'b1;
		for (int k = 0; k < n; k++) begin
			w       = ioctl_data_t'($urandom);
			pal_exp = ref_pal_shift(pal_exp, w);
			write_download(ioctl_addr_t'(2 * k), w);
		end
		@(negedge clk_sys);
		check_pal("palette", palette, pal_exp);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		report_test("palette", start);

		start = errors;
		run_cart_load(1'b0);
		run_cart_load(1'b1);
		report_test("load", start);

		// Autosave when the menu opens, clock block included
		start = errors;
		@(negedge clk_sys);
		check_bit("sav_pending", sav_pending, 1'b0);
		@(posedge clk_sys);
		rtc_inuse <= 1'b1;
		cram_wr   <= 1'b1;
		@(posedge clk_sys);
		cram_wr <= 1'b0;
		@(negedge clk_sys);
		check_bit("sav_pending", sav_pending, 1'b1);
		exp_block   = 0;
		exp_load    = 1'b0;
		blocks_done = 0;
		@(posedge clk_sys);
		autosave   <= 1'b1;
		osd_status <= 1'b1;
		wait_transfer(ref_blocks(ram_mask_file, 1'b1));
		check_bit("sav_pending", sav_pending, 1'b0);
		@(posedge clk_sys);
		autosave   <= 1'b0;
		osd_status <= 1'b0;
		report_test("save", start);

		start = errors;
		latched = 1'b0;
		tap(5, 1'b0, latched);
		tap(30, 1'b0, latched);
		tap(5, 1'b0, latched);
		tap(5, 1'b0, latched);
		tap(5, 1'b1, latched);
		report_test("ff", start);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: gb_host_top.sv
/* Host-side glue top: download decode, cheats, palette,
   fast forward and backup RAM sequencing */
`timescale 1ns/1ns

module gb_host_top import gb_host_pkg::*; #(
	parameter int FF_HOLD_CYCLES = 20
) (
	input  logic           clk_sys,
	input  logic           reset,
	// Download port
	input  logic           ioctl_download,
	input  logic           ioctl_wr,
	input  ioctl_addr_t    ioctl_addr,
	input  ioctl_data_t    ioctl_dout,
	input  filetype_t      filetype,
	// User controls
	input  logic           ff_button,
	input  logic           osd_status,
	// Storage host
	input  logic           sd_ack,
	input  buff_addr_t     sd_buff_addr,
	input  ioctl_data_t    sd_buff_dout,
	input  logic           sd_buff_wr,
	input  logic           img_mounted,
	input  logic           img_readonly,
	input  logic [63:0]    img_size,
	// Save control and cartridge state
	input  logic           bk_load_req,
	input  logic           bk_save_req,
	input  logic           autosave,
	input  logic           cram_wr,
	input  logic           cart_has_save,
	input  block_mask_t    ram_mask_file,
	input  logic           rtc_inuse,
	input  rtc_stamp_t     rtc_timestamp,
	input  rtc_saved_t     rtc_savedtime,
	input  ioctl_data_t    bk_q,
	output download_kind_e download_kind,
	output logic           using_real_cgb_bios,
	output gg_code_t       gg_code,
	output logic           gg_reset,
	output palette_t       palette,
	output logic           fast_forward,
	output lba_t           sd_lba,
	output logic           sd_rd,
	output logic           sd_wr,
	output ioctl_data_t    sd_buff_din,
	output logic [15:0]    bk_addr,
	output ioctl_data_t    bk_data,
	output logic           bk_wr,
	output logic           bk_rtc_wr,
	output logic           bk_loading,
	output logic           sav_pending,
	output logic           sav_supported
);

	download_decoder download_decoder0 (
		.clk_sys             (clk_sys),
		.reset               (reset),
		.ioctl_download      (ioctl_download),
		.filetype            (filetype),
		.download_kind       (download_kind),
		.using_real_cgb_bios (using_real_cgb_bios)
	);

	cheat_code_loader cheat_code_loader0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.download_kind (download_kind),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.gg_code       (gg_code),
		.gg_reset      (gg_reset)
	);

	palette_loader palette_loader0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.download_kind (download_kind),
		.ioctl_wr      (ioctl_wr),
		.ioctl_dout    (ioctl_dout),
		.palette       (palette)
	);

	fast_forward_latch #(
		.FF_HOLD_CYCLES (FF_HOLD_CYCLES)
	) fast_forward_latch0 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ff_button      (ff_button),
		.ioctl_download (ioctl_download),
		.osd_status     (osd_status),
		.fast_forward   (fast_forward)
	);

	backup_ram_sequencer backup_ram_sequencer0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.download_kind (download_kind),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.autosave      (autosave),
		.osd_status    (osd_status),
		.cram_wr       (cram_wr),
		.cart_has_save (cart_has_save),
		.ram_mask_file (ram_mask_file),
		.rtc_inuse     (rtc_inuse),
		.rtc_timestamp (rtc_timestamp),
		.rtc_savedtime (rtc_savedtime),
		.sd_ack        (sd_ack),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_dout  (sd_buff_dout),
		.sd_buff_wr    (sd_buff_wr),
		.bk_q          (bk_q),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.sd_buff_din   (sd_buff_din),
		.bk_addr       (bk_addr),
		.bk_data       (bk_data),
		.bk_wr         (bk_wr),
		.bk_rtc_wr     (bk_rtc_wr),
		.bk_loading    (bk_loading),
		.sav_pending   (sav_pending),
		.sav_supported (sav_supported)
	);

endmodule

// File: backup_ram_sequencer.sv
/* Backup RAM load and save sequencer, block by block, with the
   extra RTC block and the save data steering */
`timescale 1ns/1ns

module backup_ram_sequencer import gb_host_pkg::*; (
	input  logic           clk_sys,
	input  logic           reset,
	input  download_kind_e download_kind,
	input  logic           img_mounted,
	input  logic           img_readonly,
	input  logic [63:0]    img_size,
	input  logic           bk_load_req,
	input  logic           bk_save_req,
	input  logic           autosave,
	input  logic           osd_status,
	input  logic           cram_wr,
	input  logic           cart_has_save,
	input  block_mask_t    ram_mask_file,
	input  logic           rtc_inuse,
	input  rtc_stamp_t     rtc_timestamp,
	input  rtc_saved_t     rtc_savedtime,
	input  logic           sd_ack,
	input  buff_addr_t     sd_buff_addr,
	input  ioctl_data_t    sd_buff_dout,
	input  logic           sd_buff_wr,
	input  ioctl_data_t    bk_q,
	output lba_t           sd_lba,
	output logic           sd_rd,
	output logic           sd_wr,
	output ioctl_data_t    sd_buff_din,
	output logic [15:0]    bk_addr,
	output ioctl_data_t    bk_data,
	output logic           bk_wr,
	output logic           bk_rtc_wr,
	output logic           bk_loading,
	output logic           sav_pending,
	output logic           sav_supported
);

	typedef enum logic {BK_IDLE, BK_ACTIVE} bk_state_e;

	bk_state_e bk_state;
	logic      downloading;
	logic      old_downloading;
	logic      dl_start;
	logic      dl_end;
	logic      bk_ena;
	logic      new_load;
	logic      bk_load;
	logic      bk_save;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      ack_rise;
	logic      ack_fall;
	logic      rtc_block;
	logic      last_block;

	assign downloading = (download_kind == KIND_CART);
	assign dl_start    = !old_downloading && downloading;
	assign dl_end      = old_downloading && !downloading;
	assign ack_rise    = !old_ack && sd_ack;
	assign ack_fall    = old_ack && !sd_ack;

	assign sav_supported = cart_has_save && bk_ena;
	assign bk_load = bk_load_req | new_load;
	assign bk_save = bk_save_req | (sav_pending & osd_status & autosave);

	// Blocks past the save RAM hold the clock state
	assign rtc_block  = sd_lba[7:0] > ram_mask_file;
	assign last_block = rtc_inuse ? rtc_block : (sd_lba[7:0] >= ram_mask_file);

	////////////////////
	// Enable and flags
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_downloading <= 1'b0;
			bk_ena          <= 1'b0;
			new_load        <= 1'b0;
			sav_pending     <= 1'b0;
		end else begin
			old_downloading <= downloading;
			if (dl_start)
				bk_ena <= 1'b0;
			// Save image is mounted before the cart download ends
			if (downloading && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (dl_end && sav_supported)
				new_load <= 1'b1;
			else if (bk_state != BK_IDLE)
				new_load <= 1'b0;

			if (cram_wr && !osd_status && sav_supported)
				sav_pending <= 1'b1;
			else if (bk_state != BK_IDLE)
				sav_pending <= 1'b0;
		end
	end

	////////////////////
	// Transfer FSM
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			bk_loading <= 1'b0;
			bk_state   <= BK_IDLE;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack  <= sd_ack;

			// Host has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (bk_state)
				BK_IDLE: begin
					if (bk_ena && ((!old_load && bk_load) || (!old_save && bk_save))) begin
						bk_state   <= BK_ACTIVE;
						bk_loading <= bk_load;
						sd_lba     <= '0;
						sd_rd      <= bk_load;
						sd_wr      <= !bk_load;
					end
					if (dl_end && |img_size && bk_ena) begin
						bk_state   <= BK_ACTIVE;
						bk_loading <= 1'b1;
						sd_lba     <= '0;
						sd_rd      <= 1'b1;
						sd_wr      <= 1'b0;
					end
				end
				BK_ACTIVE: begin
					if (ack_fall) begin
						if (last_block) begin
							bk_loading <= 1'b0;
							bk_state   <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= bk_loading;
							sd_wr  <= !bk_loading;
						end
					end
				end
				default: bk_state <= BK_IDLE;
			endcase
		end
	end

	////////////////////
	// Data steering
	////////////////////

	assign bk_addr   = {sd_lba[7:0], sd_buff_addr};
	assign bk_data   = sd_buff_dout;
	assign bk_wr     = !rtc_block && sd_buff_wr && sd_ack;
	assign bk_rtc_wr = rtc_block && sd_buff_wr && sd_ack;

	// The RTC block holds the timestamp, the saved time, then padding
	always_comb begin
		if (!rtc_block) begin
			sd_buff_din = bk_q;
		end else begin
			case (sd_buff_addr)
				8'd0:    sd_buff_din = rtc_timestamp[15:0];
				8'd1:    sd_buff_din = rtc_timestamp[31:16];
				8'd2:    sd_buff_din = rtc_savedtime[15:0];
				8'd3:    sd_buff_din = rtc_savedtime[31:16];
				8'd4:    sd_buff_din = rtc_savedtime[47:32];
				default: sd_buff_din = 16'hFFFF;
			endcase
		end
	end

	rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr)
	);

	// Request must be gone by the cycle after the host acknowledges
	req_drops_after_ack: assert property (
		@(posedge clk_sys) disable iff (reset) $rose(sd_ack) |=> !(sd_rd || sd_wr)
	);

	// Clock words only go out when the cartridge has a clock
	bk_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset) bk_rtc_wr |-> rtc_inuse && !bk_wr
	);

endmodule

// File: fast_forward_latch.sv
/* Fast-forward button with tap-to-latch behaviour */
`timescale 1ns/1ns

module fast_forward_latch #(
	parameter int FF_HOLD_CYCLES = 20
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic ff_button,
	input  logic ioctl_download,
	input  logic osd_status,
	output logic fast_forward
);

	localparam int CNT_W = $clog2(FF_HOLD_CYCLES + 1);
	localparam logic [CNT_W-1:0] HOLD_MAX = CNT_W'(FF_HOLD_CYCLES);

	logic             press;
	logic             last_press;
	logic             ff_latch;
	logic             ff_was_held;
	logic [CNT_W-1:0] ff_count;

	// Button is ignored while loading or in the menu
	assign press = ff_button && !ioctl_download && !osd_status;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_press   <= 1'b0;
			ff_latch     <= 1'b0;
			ff_was_held  <= 1'b0;
			ff_count     <= '0;
			fast_forward <= 1'b0;
		end else begin
			last_press <= press;

			// Saturates so long holds never wrap into a tap
			if (press && ff_count != HOLD_MAX)
				ff_count <= ff_count + 1'b1;

			if (!last_press && press) begin
				ff_latch <= 1'b0;
				ff_count <= '0;
			end

			// On release a short tap latches unless the last release already did
			if (last_press && !press) begin
				ff_was_held <= 1'b0;
				if (ff_count < HOLD_MAX && !ff_was_held) begin
					ff_was_held <= 1'b1;
					ff_latch    <= 1'b1;
				end
			end

			fast_forward <= press | ff_latch;
		end
	end

endmodule

// File: palette_loader.sv
/* Custom four-colour palette shift register */
`timescale 1ns/1ns

module palette_loader import gb_host_pkg::*; (
	input  logic           clk_sys,
	input  logic           reset,
	input  download_kind_e download_kind,
	input  logic           ioctl_wr,
	input  ioctl_data_t    ioctl_dout,
	output palette_t       palette
);

	logic pal_wr;

	assign pal_wr = (download_kind == KIND_PALETTE) && ioctl_wr;

	// Palette file bytes come in little endian pairs
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette <= PALETTE_RESET;
		end else if (pal_wr) begin
			palette <= {palette[111:0], ioctl_dout[7:0], ioctl_dout[15:8]};
		end
	end

endmodule

// File: cheat_code_loader.sv
/* Cheat record assembly from the 16-bit download stream,
   plus the cheat-table reset */
`timescale 1ns/1ns

module cheat_code_loader import gb_host_pkg::*; (
	input  logic           clk_sys,
	input  logic           reset,
	input  download_kind_e download_kind,
	input  logic           ioctl_wr,
	input  ioctl_addr_t    ioctl_addr,
	input  ioctl_data_t    ioctl_dout,
	output gg_code_t       gg_code,
	output logic           gg_reset
);

	logic code_wr;

	assign code_wr = (download_kind == KIND_CHEAT) && ioctl_wr;

	// Clear the table at the first word of a cheat file,
	// and on any cart or palette download
	assign gg_reset = (code_wr && ioctl_addr == '0) ||
		(download_kind == KIND_CART) ||
		(download_kind == KIND_PALETTE);

	////////////////////
	// Record assembly
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gg_code.strobe <= 1'b0;
		end else begin
			gg_code.strobe <= code_wr && (ioctl_addr[3:0] == 4'd14);
		end

		// Eight words per record, bottom half word first
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  gg_code.flags[15:0]    <= ioctl_dout;
				4'd2:  gg_code.flags[31:16]   <= ioctl_dout;
				4'd4:  gg_code.address[15:0]  <= ioctl_dout;
				4'd6:  gg_code.address[31:16] <= ioctl_dout;
				4'd8:  gg_code.compare[15:0]  <= ioctl_dout;
				4'd10: gg_code.compare[31:16] <= ioctl_dout;
				4'd12: gg_code.replace[15:0]  <= ioctl_dout;
				4'd14: gg_code.replace[31:16] <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// The core clocks in one code per strobe
	strobe_single_cycle: assert property (
		@(posedge clk_sys) disable iff (reset)
		gg_code.strobe |=> !gg_code.strobe
	);

endmodule

// File: download_decoder.sv
/* Download classifier and sticky CGB boot-ROM flag */
`timescale 1ns/1ns

module download_decoder import gb_host_pkg::*; (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           ioctl_download,
	input  filetype_t      filetype,
	output download_kind_e download_kind,
	output logic           using_real_cgb_bios
);

	// Megaduck shares the low six bits with the cart code, so it is tested first
	always_comb begin
		download_kind = KIND_NONE;
		if (ioctl_download) begin
			if (filetype == FT_MEGADUCK) begin
				download_kind = KIND_MEGADUCK;
			end else if (filetype[5:0] == FT_CART_LOW || filetype == FT_CART_ALT) begin
				download_kind = KIND_CART;
			end else begin
				case (filetype)
					8'd2:     download_kind = KIND_SGB_BORDER;
					8'd3:     download_kind = KIND_PALETTE;
					8'd4:     download_kind = KIND_CGB_BOOT;
					8'd5:     download_kind = KIND_DMG_BOOT;
					8'd6:     download_kind = KIND_SGB_BOOT;
					FT_CHEAT: download_kind = KIND_CHEAT;
					default:  download_kind = KIND_NONE;
				endcase
			end
		end
	end

	// Once a real CGB boot ROM was loaded it stays in use
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			using_real_cgb_bios <= 1'b0;
		end else if (download_kind == KIND_CGB_BOOT) begin
			using_real_cgb_bios <= 1'b1;
		end
	end

endmodule

// File: gb_host_pkg.sv
/* Shared types, download kinds, file-type codes and the default palette
   for the emulator host glue */
package gb_host_pkg;

	// Download port
	typedef logic [24:0] ioctl_addr_t;
	typedef logic [15:0] ioctl_data_t;
	typedef logic [7:0]  filetype_t;

	// What the active download carries
	typedef enum logic [3:0] {
		KIND_NONE,
		KIND_CART,
		KIND_MEGADUCK,
		KIND_PALETTE,
		KIND_SGB_BORDER,
		KIND_CGB_BOOT,
		KIND_DMG_BOOT,
		KIND_SGB_BOOT,
		KIND_CHEAT
	} download_kind_e;

	// Cheat record, integer fields in big endian byte order
	typedef struct packed {
		logic        strobe;
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} gg_code_t;

	// Four 24-bit colours, then 32 spare bits
	typedef logic [127:0] palette_t;

	localparam palette_t PALETTE_RESET = 128'h828214517356305A5F1A3B4900000000;

	// Backup RAM transfers
	typedef logic [31:0] lba_t;
	typedef logic [7:0]  buff_addr_t;
	typedef logic [7:0]  block_mask_t;

	// Real-time clock words
	typedef logic [31:0] rtc_stamp_t;
	typedef logic [47:0] rtc_saved_t;

	// File-type codes
	localparam logic [5:0] FT_CART_LOW = 6'h01;
	localparam filetype_t  FT_CART_ALT = 8'h80;
	localparam filetype_t  FT_MEGADUCK = 8'h81;
	localparam filetype_t  FT_CHEAT    = 8'hFF;

endpackage
